// ==== source/qspi_defines.svh ====
// QSPI fetch constants
// Flash command framing, word packing and instruction field widths
`ifndef QSPI_DEFINES_SVH
`define QSPI_DEFINES_SVH

// Flash command phase
`define QSPI_READ_CMD     8'h6B    // Quad Output Read
`define QSPI_CMD_BITS     8
`define QSPI_DUMMY_CLOCKS 32       // Per flash datasheet

// Quad read framing
`define QSPI_NIBBLE_WIDTH 4
`define QSPI_WORD_NIBBLES 6
`define QSPI_WORD_WIDTH   (`QSPI_NIBBLE_WIDTH * `QSPI_WORD_NIBBLES)
`define QSPI_CNT_WIDTH    6        // Covers command, dummy and nibble counts

// Instruction format
`define INSTR_WIDTH       18
`define OPCODE_WIDTH      4
`define OPERAND_WIDTH     (`INSTR_WIDTH - `OPCODE_WIDTH)
`define ACC_WIDTH         14
`define STALL_WIDTH       8        // Wait count from operand low byte

`endif

// ==== source/flash_pkg.sv ====
// Flash bus types
// Pin groups, output enables, quad nibble and reader FSM states
`include "qspi_defines.svh"

package flash_pkg;

    // IO3 is the most significant bit
    typedef logic [`QSPI_NIBBLE_WIDTH-1:0] nibble_t;

    // Controller driven flash pins
    typedef struct packed {
        logic cs_n;
        logic di;       // IO0 during command phase
        logic hold_n;   // IO3 during command phase
    } flash_pins_t;

    // Pad output enables, 1 drives the pad
    typedef struct packed {
        logic cs_oe;
        logic di_oe;
        logic sclk_oe;
        logic hold_n_oe;
    } flash_oe_t;

    typedef enum logic [2:0] {
        idle      = 3'b000,
        send_cmd  = 3'b001,
        dummy     = 3'b010,
        read_data = 3'b011,
        wait_data = 3'b111
    } reader_state_t;

endpackage

// ==== source/instr_pkg.sv ====
// Instruction stream types
// Word, opcode, operand, accumulator and stall count for the executor
`include "qspi_defines.svh"

package instr_pkg;

    typedef logic [`INSTR_WIDTH-1:0] instr_t;

    // Opcode in instruction bits 17..14
    typedef enum logic [`OPCODE_WIDTH-1:0] {
        op_nop  = 4'h0,
        op_load = 4'h1,
        op_add  = 4'h2,
        op_xor  = 4'h3,
        op_out  = 4'h4,
        op_wait = 4'h5
    } opcode_t;

    // Immediate in instruction bits 13..0
    typedef logic [`OPERAND_WIDTH-1:0] operand_t;

    typedef logic [`ACC_WIDTH-1:0] acc_t;

    typedef logic [`STALL_WIDTH-1:0] stall_t;

    // Field view of one instruction word
    typedef struct packed {
        opcode_t  opcode;
        operand_t operand;
    } instr_fields_t;

endpackage

// ==== source/qspi_reader.sv ====
// QSPI instruction reader
// Sends Quad Output Read to the flash, clocks out the dummy cycles and
// then streams 18-bit instructions, six nibbles per 24-bit word.
// The flash clock is gated while the consumer holds the stream.
`timescale 1ns/1ps
`include "qspi_defines.svh"

module qspi_reader
    import flash_pkg::*, instr_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        shift_data,    // Consumer ready level
    input  nibble_t     io_in,
    output flash_pins_t flash_pins,
    output logic        spi_clk,
    output flash_oe_t   flash_oe,
    output instr_t      instruction,
    output logic        valid
);

    localparam logic [`QSPI_CNT_WIDTH-1:0] cmd_last    = `QSPI_CMD_BITS;
    localparam logic [`QSPI_CNT_WIDTH-1:0] dummy_last  = `QSPI_DUMMY_CLOCKS - 1;
    localparam logic [`QSPI_CNT_WIDTH-1:0] nibble_last = `QSPI_WORD_NIBBLES - 1;

    reader_state_t                  state;
    logic [`QSPI_CNT_WIDTH-1:0]     bit_cnt;
    logic [`QSPI_CMD_BITS-1:0]      cmd_sr;       // Command bits, MSB out first
    logic [`QSPI_WORD_WIDTH-1:0]    word_sr;      // Incoming quad word
    logic                           hold_read;    // Stops the flash clock

    // Flash samples on the falling clk edge, hold only changes on the rising one
    assign spi_clk = ~clk & ~hold_read;

    assign instruction = word_sr[`INSTR_WIDTH-1:0];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state      <= idle;
            bit_cnt    <= '0;
            cmd_sr     <= '0;
            flash_pins <= '{cs_n: 1'b1, di: 1'b0, hold_n: 1'b0};
            flash_oe   <= '0;
            valid      <= 1'b0;
            hold_read  <= 1'b0;
        end else begin
            case (state)
                idle: begin
                    flash_oe   <= '{cs_oe: 1'b1, di_oe: 1'b1, sclk_oe: 1'b1, hold_n_oe: 1'b1};
                    flash_pins <= '{cs_n: 1'b1, di: 1'b0, hold_n: 1'b1};
                    cmd_sr     <= `QSPI_READ_CMD;
                    bit_cnt    <= '0;
                    valid      <= 1'b0;
                    hold_read  <= 1'b0;
                    state      <= send_cmd;
                end

                send_cmd: begin
                    flash_pins.cs_n <= 1'b0;
                    flash_pins.di   <= cmd_sr[`QSPI_CMD_BITS-1];
                    cmd_sr          <= {cmd_sr[`QSPI_CMD_BITS-2:0], 1'b0};
                    // One extra cycle since cs_n drops with the first bit
                    if (bit_cnt == cmd_last) begin
                        bit_cnt <= '0;
                        state   <= dummy;
                    end else begin
                        bit_cnt <= bit_cnt + 1'b1;
                    end
                end

                dummy: begin
                    if (bit_cnt == dummy_last) begin
                        flash_oe.di_oe     <= 1'b0;    // Flash drives all four IOs
                        flash_oe.hold_n_oe <= 1'b0;
                        bit_cnt            <= '0;
                        state              <= read_data;
                    end else begin
                        bit_cnt <= bit_cnt + 1'b1;
                    end
                end

                read_data: begin
                    if (bit_cnt == nibble_last) begin
                        bit_cnt <= '0;
                        valid   <= 1'b1;               // Word complete
                        if (!shift_data) begin
                            hold_read <= 1'b1;         // Gate before the next flash edge
                            state     <= wait_data;
                        end
                    end else begin
                        bit_cnt <= bit_cnt + 1'b1;
                        valid   <= 1'b0;
                    end
                end

                wait_data: begin
                    // Word taken in the cycle shift_data is seen high
                    if (shift_data) begin
                        valid     <= 1'b0;
                        hold_read <= 1'b0;
                        state     <= read_data;
                    end
                end

                default: begin
                    state <= idle;
                end
            endcase
        end
    end

    // Nibble shifter, IO3 lands in the high bit of each nibble
    always_ff @(posedge clk) begin
        if (state == read_data) begin
            word_sr <= {word_sr[`QSPI_WORD_WIDTH-`QSPI_NIBBLE_WIDTH-1:0], io_in};
        end
    end

endmodule

// ==== source/stream_executor.sv ====
// Streaming accumulator machine
// Executes each accepted instruction on the next edge and stalls the
// instruction stream through shift_data while a wait counts down.
`timescale 1ns/1ps

module stream_executor
    import instr_pkg::*;
(
    input  logic   clk,
    input  logic   rst_n,
    input  instr_t instruction,
    input  logic   valid,
    output logic   shift_data,
    output acc_t   out_data,
    output logic   out_strobe
);

    instr_fields_t fields;
    logic          accept;
    logic          is_out;
    logic          is_wait;
    stall_t        wait_count;
    acc_t          acc;
    acc_t          acc_next;
    stall_t        stall_cnt;

    assign fields     = instr_fields_t'(instruction);
    assign accept     = valid & shift_data;
    assign is_out     = accept && (fields.opcode == op_out);
    assign is_wait    = accept && (fields.opcode == op_wait);
    assign wait_count = fields.operand[$bits(stall_t)-1:0];    // Operand bits 7..0

    // Accumulator update
    always_comb begin
        acc_next = acc;
        if (accept) begin
            case (fields.opcode)
                op_load: acc_next = fields.operand;
                op_add:  acc_next = acc + fields.operand;    // Wraps at 14 bits
                op_xor:  acc_next = acc ^ fields.operand;
                default: acc_next = acc;                     // nop, out, wait, unknown
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            acc <= '0;
        end else begin
            acc <= acc_next;
        end
    end

    // Stall counter, shift_data tracks a zero count
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            stall_cnt  <= '0;
            shift_data <= 1'b1;
        end else if (is_wait) begin
            stall_cnt  <= wait_count;
            shift_data <= (wait_count == '0);
        end else if (stall_cnt != '0) begin
            stall_cnt  <= stall_cnt - 1'b1;
            shift_data <= (stall_cnt == stall_t'(1));    // Last stall cycle
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_strobe <= 1'b0;
        end else begin
            out_strobe <= is_out;
        end
    end

    // Value before this instruction, out leaves acc unchanged
    always_ff @(posedge clk) begin
        if (is_out) begin
            out_data <= acc;
        end
    end

endmodule

// ==== source/flash_fetch_top.sv ====
// Flash fetch subsystem top
// Joins the QSPI reader and the stream executor and maps the
// flash pads and the output port.
`timescale 1ns/1ps

module flash_fetch_top
    import flash_pkg::*, instr_pkg::*;
(
    input  logic clk,
    input  logic rst_n,
    input  logic spi_io0,
    input  logic spi_io1,
    input  logic spi_io2,
    input  logic spi_io3,
    output logic spi_clk,
    output logic spi_cs_n,
    output logic spi_di,
    output logic spi_hold_n,
    output logic spi_cs_oe,
    output logic spi_di_oe,
    output logic spi_sclk_oe,
    output logic spi_hold_n_oe,
    output acc_t out_data,
    output logic out_strobe
);

    nibble_t     io_in;
    flash_pins_t flash_pins;
    flash_oe_t   flash_oe;
    instr_t      instruction;
    logic        valid;
    logic        shift_data;

    assign io_in = {spi_io3, spi_io2, spi_io1, spi_io0};    // IO3 on top

    assign spi_cs_n   = flash_pins.cs_n;
    assign spi_di     = flash_pins.di;
    assign spi_hold_n = flash_pins.hold_n;

    assign spi_cs_oe     = flash_oe.cs_oe;
    assign spi_di_oe     = flash_oe.di_oe;
    assign spi_sclk_oe   = flash_oe.sclk_oe;
    assign spi_hold_n_oe = flash_oe.hold_n_oe;

    qspi_reader reader0 (
        .clk         (clk),
        .rst_n       (rst_n),
        .shift_data  (shift_data),
        .io_in       (io_in),
        .flash_pins  (flash_pins),
        .spi_clk     (spi_clk),
        .flash_oe    (flash_oe),
        .instruction (instruction),
        .valid       (valid)
    );

    stream_executor executor0 (
        .clk         (clk),
        .rst_n       (rst_n),
        .instruction (instruction),
        .valid       (valid),
        .shift_data  (shift_data),
        .out_data    (out_data),
        .out_strobe  (out_strobe)
    );

endmodule

// ==== dv/flash_model.sv ====
// Behavioral quad SPI flash
// Checks the Quad Output Read command and the dummy phase, then streams
// 24-bit words from mem, most significant nibble first
`timescale 1ns/1ps
`include "qspi_defines.svh"

module flash_model (
    input  logic spi_clk,
    input  logic cs_n,
    input  logic di,
    input  logic di_oe,
    input  logic hold_n_oe,
    output logic io0,
    output logic io1,
    output logic io2,
    output logic io3,
    output logic error
);

    localparam int cmd_clocks = `QSPI_CMD_BITS;
    localparam int data_start = `QSPI_CMD_BITS + `QSPI_DUMMY_CLOCKS;    // Last dummy clock
    localparam int mem_words  = 64;

    logic [`QSPI_WORD_WIDTH-1:0] mem [0:mem_words-1];    // Loaded by the testbench
    logic [`QSPI_WORD_WIDTH-1:0] word;
    logic [`QSPI_CMD_BITS-1:0]   cmd_byte;
    logic [3:0]                  nibble;
    int unsigned                 edge_cnt;
    int unsigned                 nibble_cnt;                // Nibbles sent so far

    assign {io3, io2, io1, io0} = nibble;

    initial begin
        edge_cnt   = 0;
        nibble_cnt = 0;
        cmd_byte   = '0;
        nibble     = 4'h0;
        error      = 1'b0;
    end

    always @(posedge spi_clk or posedge cs_n) begin
        if (cs_n) begin
            edge_cnt = 0;                                   // Deselected, new command next
        end else begin
            edge_cnt = edge_cnt + 1;
            if (edge_cnt <= cmd_clocks) begin
                cmd_byte = {cmd_byte[`QSPI_CMD_BITS-2:0], di};    // MSB first
                if (edge_cnt == cmd_clocks) begin
                    assert (cmd_byte == `QSPI_READ_CMD) else begin
                        $display("Mismatch cmd_byte: got 0x%h, expected 0x%h",
                                 cmd_byte, `QSPI_READ_CMD);
                        error = 1'b1;
                    end
                end
            end else if (edge_cnt == data_start) begin
                assert (di_oe && hold_n_oe) else begin
                    $display("Controller released IO0 or IO3 before the last dummy clock");
                    error = 1'b1;
                end
            end else if (edge_cnt > data_start) begin
                if (edge_cnt == data_start + 1) begin
                    assert (!di_oe && !hold_n_oe) else begin
                        $display("Controller still drives IO0 or IO3 after the dummy clocks");
                        error = 1'b1;
                    end
                end
                // Past the program the flash reads as zero, a nop
                if (nibble_cnt / `QSPI_WORD_NIBBLES < mem_words) begin
                    word = mem[nibble_cnt / `QSPI_WORD_NIBBLES];
                end else begin
                    word = '0;
                end
                nibble = 4'(word >> (4 * (`QSPI_WORD_NIBBLES - 1
                                          - nibble_cnt % `QSPI_WORD_NIBBLES)));
                nibble_cnt = nibble_cnt + 1;
            end
        end
    end

endmodule

// ==== dv/qspi_assert.sv ====
// QSPI reader bus protocol checks
// Watches chip select in the read phase, the word handshake and the
// gated flash clock while the reader waits for the consumer
`timescale 1ns/1ps

module qspi_assert
    import flash_pkg::*;
(
    input logic          clk,
    input logic          rst_n,
    input logic          shift_data,
    input logic          valid,
    input logic          spi_clk,
    input flash_pins_t   flash_pins,
    input reader_state_t state
);

    logic violation = 1'b0;    // Sticky, any failed property

    cs_low_in_read: assert property (@(posedge clk) disable iff (!rst_n)
        (state inside {read_data, wait_data}) |-> !flash_pins.cs_n)
    else begin
        $error("Chip select went high during the read phase");
        violation = 1'b1;
    end

    valid_taken_once: assert property (@(posedge clk) disable iff (!rst_n)
        (valid && shift_data) |=> !valid)
    else begin
        $error("Valid stayed high after the consumer took the word");
        violation = 1'b1;
    end

    clk_gated_in_wait: assert property (@(posedge clk) disable iff (!rst_n)
        (state == wait_data) |-> !spi_clk)
    else begin
        $error("Flash clock toggled while the reader waited for the consumer");
        violation = 1'b1;
    end

endmodule

bind qspi_reader qspi_assert assert0 (
    .clk        (clk),
    .rst_n      (rst_n),
    .shift_data (shift_data),
    .valid      (valid),
    .spi_clk    (spi_clk),
    .flash_pins (flash_pins),
    .state      (state)
);

// ==== dv/tb_flash_fetch.sv ====
// Testbench for the flash fetch subsystem
// Streams an LCG generated program from the flash model and checks each
// out strobe against a reference accumulator
`timescale 1ns/1ps
`include "qspi_defines.svh"

module tb_flash_fetch
    import instr_pkg::*;
();

    localparam int prog_words   = 64;
    localparam int setup_cycles = 42;    // Idle, command and dummy phases
    localparam int word_cycles  = `QSPI_WORD_NIBBLES;

    logic clk;
    logic rst_n;
    logic spi_io0, spi_io1, spi_io2, spi_io3;
    logic spi_clk, spi_cs_n, spi_di, spi_hold_n;
    logic spi_cs_oe, spi_di_oe, spi_sclk_oe, spi_hold_n_oe;
    acc_t out_data;
    logic out_strobe;
    logic flash_error;

    logic [31:0] rand_state;
    acc_t        expected_outs[$];
    int          strobe_count  = 0;
    int          wait_sum      = 0;
    logic        program_ready = 1'b0;
    logic        read_phase    = 1'b0;

    flash_fetch_top dut0 (.*);

    flash_model flash0 (
        .spi_clk   (spi_clk),
        .cs_n      (spi_cs_n),
        .di        (spi_di),
        .di_oe     (spi_di_oe),
        .hold_n_oe (spi_hold_n_oe),
        .io0       (spi_io0),
        .io1       (spi_io1),
        .io2       (spi_io2),
        .io3       (spi_io3),
        .error     (flash_error)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic stop_with_failure();
        $display("Finished with errors");
        $fatal(1, "Stopping on the first failed check");
    endtask

    function automatic logic [31:0] next_rand();
        rand_state = rand_state * 32'd1664525 + 32'd1013904223;
        return rand_state;
    endfunction

    // Accumulator after one instruction
    function automatic acc_t ref_step(input acc_t acc, input instr_t word);
        case (word[17:14])
            op_load: return word[13:0];
            op_add:  return acc + word[13:0];    // Wraps at 14 bits
            op_xor:  return acc ^ word[13:0];
            default: return acc;
        endcase
    endfunction

    task automatic build_program();
        acc_t        acc;
        logic [31:0] r;
        logic [3:0]  op;
        logic [13:0] imm;
        instr_t      word;
        int          i;
        acc        = '0;
        rand_state = 32'd75;
        for (i = 0; i < prog_words; i++) begin
            r   = next_rand();
            imm = r[29:16];
            r   = next_rand();
            case (r[31:16] % 10)
                0:       op = op_load;
                1:       op = op_add;
                2:       op = op_xor;
                3, 4:    op = op_out;
                5, 6, 7: op = op_wait;
                8:       op = op_nop;
                default: op = 4'h6 + 4'(r[19:16] % 10);    // Unused opcodes
            endcase
            if (op == op_wait) begin
                imm[7:4] = 4'h0;                          // At most 15 stall cycles
                wait_sum += imm[7:0];
            end
            word = {op, imm};
            if (op == op_out) begin
                expected_outs.push_back(acc);
            end
            acc = ref_step(acc, word);
            flash0.mem[i] = {6'b0, word};
        end
    endtask

    task automatic check_reset_outputs();
        assert (!out_strobe && spi_cs_n && !spi_hold_n && !spi_cs_oe && !spi_di_oe
                && !spi_sclk_oe && !spi_hold_n_oe) else begin
            $display("Outputs not inactive in reset: out_strobe %b, cs_n %b, hold_n %b",
                     out_strobe, spi_cs_n, spi_hold_n);
            $display("Enables in reset: cs %b, di %b, sclk %b, hold_n %b",
                     spi_cs_oe, spi_di_oe, spi_sclk_oe, spi_hold_n_oe);
            stop_with_failure();
        end
    endtask

    initial begin : main
        int i;
        rst_n = 1'b0;
        build_program();
        program_ready = 1'b1;
        for (i = 0; i < 4; i++) begin
            @(posedge clk);
            if (i == 3) begin
                rst_n <= 1'b1;
            end
            @(negedge clk);
            check_reset_outputs();
        end
        repeat (setup_cycles) @(posedge clk);
        read_phase = 1'b1;
        // Two words past the program means every program word was taken
        wait (flash0.nibble_cnt >= (prog_words + 2) * word_cycles);
        repeat (20) @(posedge clk);
        @(negedge clk);
        assert (strobe_count == expected_outs.size()) else
            $display("Saw %0d out strobes but the program holds %0d out instructions",
                     strobe_count, expected_outs.size());
        if (strobe_count == expected_outs.size()) begin
            $display("Finished with no errors");
            $finish;
        end else begin
            stop_with_failure();
        end
    end

    always @(negedge clk) begin : compare
        if (out_strobe === 1'b1) begin
            assert (strobe_count < expected_outs.size()) else begin
                $display("Out strobe %0d has no matching out instruction", strobe_count);
                stop_with_failure();
            end
            assert (out_data === expected_outs[strobe_count]) else begin
                $display("Mismatch out_data: got 0x%h, expected 0x%h at strobe %0d",
                         out_data, expected_outs[strobe_count], strobe_count);
                stop_with_failure();
            end
            strobe_count++;
        end
    end

    always @(negedge clk) begin : bus_monitor
        if (read_phase) begin
            assert (spi_cs_oe && spi_sclk_oe && !spi_di_oe && !spi_hold_n_oe && !spi_cs_n)
            else begin
                $display("Wrong bus setup in read phase: cs_n %b, enables %b%b%b%b",
                         spi_cs_n, spi_cs_oe, spi_di_oe, spi_sclk_oe, spi_hold_n_oe);
                stop_with_failure();
            end
        end
        // Hold must be released whenever the controller drives IO3
        if (spi_hold_n_oe === 1'b1) begin
            assert (spi_hold_n === 1'b1) else begin
                $display("Mismatch spi_hold_n: got 0x%h, expected 0x1", spi_hold_n);
                stop_with_failure();
            end
        end
        assert (dut0.reader0.assert0.violation !== 1'b1) else begin
            $display("A bus protocol property of the QSPI reader failed");
            stop_with_failure();
        end
    end

    // Flash model errors appear on the falling clk edge
    always @(posedge clk) begin
        assert (flash_error !== 1'b1) else begin
            $display("Flash model saw a bad command or dummy phase");
            stop_with_failure();
        end
    end

    initial begin : watchdog
        int limit;
        wait (program_ready);
        limit = 2 * (setup_cycles + prog_words * word_cycles + wait_sum);
        repeat (limit) @(posedge clk);
        $display("Timeout: run still going after %0d clock cycles", limit);
        stop_with_failure();
    end

endmodule

// ==== files.f ====
+incdir+source
source/flash_pkg.sv
source/instr_pkg.sv
source/qspi_reader.sv
source/stream_executor.sv
source/flash_fetch_top.sv
dv/flash_model.sv
dv/qspi_assert.sv
dv/tb_flash_fetch.sv
